/* bit_packer.sv */
/*
 * Bit packer. Appends fields of 1 to 32 bits, LSB first, into a
 * 64-bit accumulator and pushes each completed 32-bit word.
 * The field_last field flushes the zero-filled remainder
 */
`timescale 1ns/1ps
`include "gzip_defines.svh"

module bit_packer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            field_valid,
	input  gzip_pkg::size_t field_size,
	input  gzip_pkg::word_t field_data,
	input  logic            field_last,
	input  logic            almost_full,
	output logic            ready,
	output logic            word_push,
	output gzip_pkg::word_t word_data,
	output logic            word_last
);

	localparam int W     = `GZ_WORD_W;
	localparam int ACC_W = 2 * `GZ_WORD_W;

	logic [ACC_W-1:0] acc;         // Bits held, upper part always zero
	logic [6:0]       bit_cnt;     // Valid bits in acc, below W between fields
	logic             flush_pend;  // Remainder still owed after the last field
	logic             take;
	logic [ACC_W-1:0] field_bits;
	logic [ACC_W-1:0] acc_nxt;
	logic [6:0]       cnt_nxt;

	// No new field while the flush word is still to go out
	assign ready = ~almost_full & ~flush_pend;
	assign take  = field_valid & ready;

	// Bits above field_size are cleared so zero fill comes for free
	assign field_bits = {{W{1'b0}}, field_data} & ~({ACC_W{1'b1}} << field_size);
	assign acc_nxt    = acc | (field_bits << bit_cnt);
	assign cnt_nxt    = bit_cnt + 7'(field_size);

	// ==============================
	// Accumulator and push strobes
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc        <= '0;
			bit_cnt    <= '0;
			flush_pend <= 1'b0;
			word_push  <= 1'b0;
			word_last  <= 1'b0;
		end else begin
			word_push <= 1'b0;
			word_last <= 1'b0;
			if (flush_pend) begin
				word_push  <= 1'b1;            // Partial word, closes the stream
				word_last  <= 1'b1;
				acc        <= '0;
				bit_cnt    <= '0;
				flush_pend <= 1'b0;
			end else if (take) begin
				if (cnt_nxt >= 7'(W)) begin
					word_push <= 1'b1;
					acc       <= acc_nxt >> W;
					bit_cnt   <= cnt_nxt - 7'(W);
					if (field_last) begin
						if (cnt_nxt == 7'(W))
							word_last  <= 1'b1;   // Word boundary, this word ends the stream
						else
							flush_pend <= 1'b1;   // Leftover bits follow next cycle
					end
				end else if (field_last) begin
					word_push <= 1'b1;         // Short stream fits in one word
					word_last <= 1'b1;
					acc       <= '0;
					bit_cnt   <= '0;
				end else begin
					acc     <= acc_nxt;
					bit_cnt <= cnt_nxt;
				end
			end
		end
	end

	// Output word, only read by the FIFO together with word_push
	always_ff @(posedge clk) begin
		if (flush_pend)
			word_data <= acc[W-1:0];
		else if (take)
			word_data <= acc_nxt[W-1:0];
	end

endmodule

/* crc32_engine.sv */
/*
 * Byte-wide CRC32 accumulator, reflected polynomial.
 * Eight bit steps per valid byte, restart back to the preset
 * value, output already XORed with the final value
 */
`timescale 1ns/1ps
`include "gzip_defines.svh"

module crc32_engine (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            byte_valid,
	input  gzip_pkg::byte_t byte_data,
	input  logic            restart,
	output gzip_pkg::word_t crc
);

	gzip_pkg::word_t crc_q;      // Running remainder, not yet inverted
	gzip_pkg::word_t crc_nxt;    // Remainder after the current byte

	// ==============================
	// Eight shift steps for one byte
	// ==============================
	always_comb begin
		crc_nxt = crc_q ^ {24'b0, byte_data};    // LSB of the byte goes in first
		for (int i = 0; i < 8; i++) begin
			if (crc_nxt[0])
				crc_nxt = (crc_nxt >> 1) ^ `GZ_CRC_POLY;
			else
				crc_nxt = crc_nxt >> 1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc_q <= `GZ_CRC_INIT;
		else if (restart)
			crc_q <= `GZ_CRC_INIT;   // New stream starts from the preset, wins over a byte
		else if (byte_valid)
			crc_q <= crc_nxt;
	end

	// gzip stores the inverted remainder
	assign crc = crc_q ^ `GZ_CRC_INIT;

endmodule

/* gzip_defines.svh */
/*
 * Shared widths, FIFO depths, CRC32 constants and header field
 * positions for the stored-block gzip member builder
 */
`ifndef GZIP_DEFINES_SVH
`define GZIP_DEFINES_SVH

// ==============================
// Data path widths
// ==============================
`define GZ_WORD_W         32             // Host and output word width
`define GZ_LEN_W          16             // LEN field of a stored block
`define GZ_SIZE_W         6              // Packer field size, holds 0 to 32

// ==============================
// FIFO depths, as log2 of entries
// ==============================
`define GZ_IN_DEPTH_LOG   4
`define GZ_OUT_DEPTH_LOG  4

// ==============================
// CRC32 (ISO 3309, reflected form)
// ==============================
`define GZ_CRC_POLY       32'hEDB8_8320
`define GZ_CRC_INIT       32'hFFFF_FFFF  // Preset value, reused as the final XOR

// Header word layout: LEN sits in bits 15:0, BFINAL in bit 24
`define GZ_BFINAL_BIT     24

`endif

/* gzip_pkg.sv */
/*
 * Data types shared by the gzip stored-block design:
 * word, byte, length and field-size types, and the
 * block controller state encoding
 */
`include "gzip_defines.svh"

package gzip_pkg;

	// ==============================
	// Data types
	// ==============================

	// One host or output word
	typedef logic [`GZ_WORD_W-1:0] word_t;

	typedef logic [7:0] byte_t;               // A single data byte

	// Byte count of one stored block
	typedef logic [`GZ_LEN_W-1:0] len_t;

	typedef logic [`GZ_SIZE_W-1:0] size_t;    // Number of valid bits in a packer field

	// ==============================
	// Block controller states
	// ==============================

	// The trailer is only produced after a block with BFINAL set
	typedef enum logic [2:0] {
		IDLE,            // Wait for a header word, or start a pending trailer
		BLOCK_HDR,       // Send BFINAL and BTYPE, padded to a byte
		BLOCK_LEN,       // Send LEN and NLEN as one 32-bit field
		LOAD_BYTE,       // Send data bytes, byte 0 of each word first
		TRAILER_CRC,     // Send the CRC32 of every data byte in the stream
		TRAILER_ISIZE    // Send the byte count and close the stream
	} ctrl_state_t;

endpackage

/* gzip_stored_top.sv */
/*
 * gzip member builder for stored deflate blocks.
 * Input FIFO, block controller, CRC32 engine, bit packer,
 * output FIFO with last flag, and the sticky done flag
 */
`timescale 1ns/1ps
`include "gzip_defines.svh"

module gzip_stored_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_push,
	input  gzip_pkg::word_t in_data,
	output logic            in_full,
	input  logic            out_pop,
	output gzip_pkg::word_t out_data,
	output logic            out_last,
	output logic            out_empty,
	output logic            done
);

	logic            in_empty;
	logic            in_pop;
	gzip_pkg::word_t in_head;
	logic            field_valid;
	gzip_pkg::size_t field_size;
	gzip_pkg::word_t field_data;
	logic            field_last;
	logic            pack_ready;
	logic            byte_valid;
	gzip_pkg::byte_t byte_data;
	logic            crc_restart;
	gzip_pkg::word_t crc;
	logic            word_push;
	gzip_pkg::word_t word_data;
	logic            word_last;
	logic            out_almost_full;

	// ==============================
	// Input side
	// ==============================
	sync_fifo #(.WIDTH(`GZ_WORD_W), .DEPTH_LOG(`GZ_IN_DEPTH_LOG)) in_fifo (
		.clk, .rst_n,
		.push(in_push), .din(in_data), .full(in_full), .almost_full(),
		.pop(in_pop), .dout(in_head), .empty(in_empty)
	);

	stored_block_ctrl ctrl (
		.clk, .rst_n,
		.fifo_empty(in_empty), .fifo_data(in_head), .fifo_pop(in_pop),
		.ready(pack_ready),
		.field_valid, .field_size, .field_data, .field_last,
		.byte_valid, .byte_data, .crc_restart, .crc
	);

	crc32_engine crc_eng (
		.clk, .rst_n,
		.byte_valid, .byte_data, .restart(crc_restart), .crc
	);

	// ==============================
	// Output side
	// ==============================
	bit_packer packer (
		.clk, .rst_n,
		.field_valid, .field_size, .field_data, .field_last,
		.almost_full(out_almost_full), .ready(pack_ready),
		.word_push, .word_data, .word_last
	);

	// Last flag rides along as bit 32
	sync_fifo #(.WIDTH(`GZ_WORD_W + 1), .DEPTH_LOG(`GZ_OUT_DEPTH_LOG)) out_fifo (
		.clk, .rst_n,
		.push(word_push), .din({word_last, word_data}), .full(), .almost_full(out_almost_full),
		.pop(out_pop), .dout({out_last, out_data}), .empty(out_empty)
	);

	// Interrupt, set by the first stream end and held until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (word_push && word_last)
			done <= 1'b1;
	end

endmodule

/* project.f */
+incdir+.
gzip_pkg.sv
sync_fifo.sv
crc32_engine.sv
stored_block_ctrl.sv
bit_packer.sv
gzip_stored_top.sv
tb_gzip_stored.sv

/* run.sh */
#!/bin/sh
# Compile and run the gzip stored-block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_gzip_stored

status=0
out=$(./obj_dir/Vtb_gzip_stored 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

/* stored_block_ctrl.sv */
/*
 * Stored-block sequencer. Reads header and data words from the
 * input FIFO and hands the header byte, LEN/NLEN, data bytes and
 * the CRC32/ISIZE trailer to the bit packer. Also drives the CRC
 * engine and keeps the ISIZE byte count
 */
`timescale 1ns/1ps
`include "gzip_defines.svh"

module stored_block_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              fifo_empty,
	input  gzip_pkg::word_t   fifo_data,
	output logic              fifo_pop,
	input  logic              ready,
	output logic              field_valid,
	output gzip_pkg::size_t   field_size,
	output gzip_pkg::word_t   field_data,
	output logic              field_last,
	output logic              byte_valid,
	output gzip_pkg::byte_t   byte_data,
	output logic              crc_restart,
	input  gzip_pkg::word_t   crc
);

	gzip_pkg::ctrl_state_t state;
	gzip_pkg::ctrl_state_t state_nxt;
	gzip_pkg::len_t        remaining;     // Data bytes still to send in this block
	gzip_pkg::word_t       isize;         // Data bytes of the stream, mod 2^32
	logic [1:0]            byte_idx;      // Next byte lane of the head word
	logic                  bfinal;        // Current block closes the stream
	logic                  trailer_pend;  // End check found a final block
	logic                  take;          // Packer accepts the field this cycle
	logic                  last_byte;

	assign take      = field_valid & ready;
	assign last_byte = (remaining == `GZ_LEN_W'(1));
	assign byte_data = fifo_data[{byte_idx, 3'b000} +: 8];   // Byte 0 is bits 7:0

	// ==============================
	// Next state and field decode
	// ==============================
	always_comb begin
		state_nxt   = state;
		field_valid = 1'b0;
		field_size  = '0;
		field_data  = '0;
		field_last  = 1'b0;
		fifo_pop    = 1'b0;
		byte_valid  = 1'b0;
		crc_restart = 1'b0;

		case (state)
			gzip_pkg::IDLE: begin
				// The cycle spent here after a block is the end check, so the CRC has settled
				if (trailer_pend)
					state_nxt = gzip_pkg::TRAILER_CRC;
				else if (!fifo_empty)
					state_nxt = gzip_pkg::BLOCK_HDR;
			end
			gzip_pkg::BLOCK_HDR: begin
				// BFINAL in bit 0, BTYPE 00 above it, zero pad up to a byte
				field_valid = 1'b1;
				field_size  = `GZ_SIZE_W'(8);
				field_data  = {31'b0, fifo_data[`GZ_BFINAL_BIT]};
				if (ready) begin
					fifo_pop  = 1'b1;     // Header word is used up
					state_nxt = gzip_pkg::BLOCK_LEN;
				end
			end
			gzip_pkg::BLOCK_LEN: begin
				field_valid = 1'b1;
				field_size  = `GZ_SIZE_W'(32);
				field_data  = {~remaining, remaining};    // LEN low, NLEN high
				if (ready)
					state_nxt = (remaining == '0) ? gzip_pkg::IDLE : gzip_pkg::LOAD_BYTE;
			end
			gzip_pkg::LOAD_BYTE: begin
				field_valid = !fifo_empty;     // Wait here for the next data word
				field_size  = `GZ_SIZE_W'(8);
				field_data  = {24'b0, byte_data};
				byte_valid  = take;            // CRC update goes out with the packer write
				if (take) begin
					// Pop after lane 3, or early when the block ends mid word
					fifo_pop = last_byte | (byte_idx == 2'd3);
					if (last_byte)
						state_nxt = gzip_pkg::IDLE;
				end
			end
			gzip_pkg::TRAILER_CRC: begin
				field_valid = 1'b1;
				field_size  = `GZ_SIZE_W'(32);
				field_data  = crc;
				if (ready)
					state_nxt = gzip_pkg::TRAILER_ISIZE;
			end
			gzip_pkg::TRAILER_ISIZE: begin
				field_valid = 1'b1;
				field_size  = `GZ_SIZE_W'(32);
				field_data  = isize;
				field_last  = 1'b1;            // Makes the packer flush and tag the word
				if (ready) begin
					crc_restart = 1'b1;
					state_nxt   = gzip_pkg::IDLE;
				end
			end
			default: state_nxt = gzip_pkg::IDLE;
		endcase
	end

	// ==============================
	// State and block registers
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= gzip_pkg::IDLE;
			remaining    <= '0;
			isize        <= '0;
			byte_idx     <= '0;
			bfinal       <= 1'b0;
			trailer_pend <= 1'b0;
		end else begin
			state <= state_nxt;
			case (state)
				gzip_pkg::IDLE:
					trailer_pend <= 1'b0;             // Consumed on the way to TRAILER_CRC
				gzip_pkg::BLOCK_HDR:
					if (ready) begin
						bfinal    <= fifo_data[`GZ_BFINAL_BIT];
						remaining <= fifo_data[`GZ_LEN_W-1:0];
					end
				gzip_pkg::BLOCK_LEN:
					if (ready) begin
						byte_idx <= '0;                // Data always starts at byte 0
						if (remaining == '0)
							trailer_pend <= bfinal;    // Empty block goes straight to the end check
					end
				gzip_pkg::LOAD_BYTE:
					if (take) begin
						remaining <= remaining - 1'b1;
						byte_idx  <= byte_idx + 1'b1;  // Wraps to lane 0 with the pop
						isize     <= isize + 1'b1;
						if (last_byte)
							trailer_pend <= bfinal;
					end
				gzip_pkg::TRAILER_ISIZE:
					if (ready)
						isize <= '0;                   // Next stream counts from zero
				default: ;
			endcase
		end
	end

endmodule

/* sync_fifo.sv */
/*
 * Single-clock first-word-fall-through FIFO.
 * Head entry is visible at dout while not empty; full,
 * almost_full (under 3 free) and empty are decoded from a count
 */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH     = 32,
	parameter int DEPTH_LOG = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] din,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic [WIDTH-1:0] dout,
	output logic             empty
);

	localparam int DEPTH = 1 << DEPTH_LOG;

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [DEPTH_LOG-1:0] wr_ptr;
	logic [DEPTH_LOG-1:0] rd_ptr;
	logic [DEPTH_LOG:0]   count;      // One bit wider than the pointers, so DEPTH fits
	logic                 do_push;
	logic                 do_pop;

	// Requests against a full or empty FIFO are dropped here
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// ==============================
	// Pointers and occupancy
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;     // Wraps at DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count unchanged
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	assign dout        = mem[rd_ptr];                    // Fall-through head word
	assign full        = (count == DEPTH[DEPTH_LOG:0]);
	assign almost_full = (count > DEPTH[DEPTH_LOG:0] - 3'd3);  // Fewer than 3 entries free
	assign empty       = (count == '0);

endmodule

/* tb_gzip_model.svh */
/*
 * Reference model for the stored-block gzip testbench.
 * Bit-serial CRC32, LSB-first bit stream of the open member,
 * expected output word queues and the random block generator
 */

// Words for the DUT input side, and the words the DUT must deliver
gzip_pkg::word_t in_q[$];
gzip_pkg::word_t exp_data_q[$];
logic            exp_last_q[$];

logic            stream_bits[$];    // Bits of the open member, oldest first
gzip_pkg::byte_t stream_bytes[$];   // Data bytes of the open member

// Append a field to the member, bit 0 goes out first
function automatic void append_field(input gzip_pkg::word_t value, input int nbits);
	for (int i = 0; i < nbits; i++)
		stream_bits.push_back(value[i]);
endfunction

// CRC32 one bit at a time, straight from the reflected definition
function automatic gzip_pkg::word_t crc32_of_stream();
	gzip_pkg::word_t c;
	logic            fb;
	c = 32'hFFFF_FFFF;
	foreach (stream_bytes[n]) begin
		for (int k = 0; k < 8; k++) begin
			fb = c[0] ^ stream_bytes[n][k];   // Feedback of the shifted-out bit
			c  = c >> 1;
			if (fb)
				c = c ^ 32'hEDB8_8320;
		end
	end
	return c ^ 32'hFFFF_FFFF;
endfunction

// Trailer, then cut the member into 32-bit words with zero fill
function automatic void close_stream();
	gzip_pkg::word_t w;
	append_field(crc32_of_stream(), 32);
	append_field(gzip_pkg::word_t'(stream_bytes.size()), 32);  // ISIZE
	while (stream_bits.size() > 0) begin
		w = '0;
		for (int i = 0; i < 32 && stream_bits.size() > 0; i++)
			w[i] = stream_bits.pop_front();
		exp_data_q.push_back(w);
		exp_last_q.push_back(stream_bits.size() == 0);   // Only the final word is tagged
	end
	stream_bytes.delete();
endfunction

// Random LEN from 1 to 40
function automatic int rand_len();
	return 1 + int'(($random(seed) & 32'h7FFF_FFFF) % 40);
endfunction

// One stored block: header word, data words, and the expected bits
task automatic add_block(input logic bfinal, input int len);
	gzip_pkg::word_t w;
	gzip_pkg::byte_t b;
	in_q.push_back(gzip_pkg::word_t'({bfinal, 24'(len)}));   // BFINAL at bit 24, LEN low
	append_field({31'b0, bfinal}, 8);                         // BTYPE 00 and pad
	append_field({~16'(len), 16'(len)}, 32);                  // NLEN above LEN
	w = $random(seed);               // Lanes past the block end keep this junk
	for (int i = 0; i < len; i++) begin
		b = gzip_pkg::byte_t'($random(seed));
		w[8*(i%4) +: 8] = b;
		stream_bytes.push_back(b);
		append_field({24'b0, b}, 8);
		if (i % 4 == 3 || i == len - 1) begin
			in_q.push_back(w);
			w = $random(seed);
		end
	end
	if (bfinal)
		close_stream();
endtask

/* tb_gzip_stored.sv */
/*
 * Testbench for the stored-block gzip member builder.
 * Clock and reset, random streams from the included model,
 * input producer, stalling output consumer, compare tasks
 * and a cycle-count timeout
 */
`timescale 1ns/1ps
`include "gzip_defines.svh"

module tb_gzip_stored;

	logic            clk;
	logic            rst_n;
	logic            in_push;
	gzip_pkg::word_t in_data;
	logic            in_full;
	logic            out_pop;
	gzip_pkg::word_t out_data;
	logic            out_last;
	logic            out_empty;
	logic            done;

	integer seed;          // Shared by the model and the stall choices
	int     cycle_cnt;
	int     cycle_limit;
	int     stall_mask;    // Pop only when the random bits under this mask are zero
	logic   seen_last;     // A last word has reached the host
	logic   saw_in_full;   // The producer had to hold off on a full input FIFO

	`include "tb_gzip_model.svh"

	gzip_stored_top UUT (
		.clk, .rst_n,
		.in_push, .in_data, .in_full,
		.out_pop, .out_data, .out_last, .out_empty,
		.done
	);

	// ==============================
	// Clock and timeout
	// ==============================
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("error: timeout after %0d cycles, %0d output words never arrived",
				cycle_cnt, exp_data_q.size());
			abort_run();
		end
	end

	// ==============================
	// Checks
	// ==============================
	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_word(input gzip_pkg::word_t actual, input gzip_pkg::word_t expected);
		if (actual !== expected) begin
			$display("error at %0d ns: out_data is %h, expected %h", $time, actual, expected);
			abort_run();
		end
	endtask

	task automatic compare_last(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error at %0d ns: out_last is %b, expected %b", $time, actual, expected);
			abort_run();
		end
	endtask

	task automatic compare_done(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error at %0d ns: done is %b, expected %b", $time, actual, expected);
			abort_run();
		end
	endtask

	// Status flags such as out_empty and in_full
	task automatic compare_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// ==============================
	// Host side drivers, called on the falling edge
	// ==============================

	// in_full cannot change before the next rising edge, so a push driven here is taken
	task automatic drive_input();
		if (in_full)
			saw_in_full = 1'b1;
		if (in_q.size() > 0 && !in_full) begin
			in_push = 1'b1;
			in_data = in_q.pop_front();
		end else begin
			in_push = 1'b0;
		end
	endtask

	task automatic drive_output();
		logic exp_last;
		out_pop = 1'b0;
		if (!out_empty && ($random(seed) & stall_mask) == 0) begin
			if (exp_data_q.size() == 0) begin
				$display("error: at %0d ns the DUT offers a word the model does not expect", $time);
				abort_run();
			end else begin
				exp_last = exp_last_q.pop_front();
				compare_word(out_data, exp_data_q.pop_front());
				compare_last(out_last, exp_last);
				if (seen_last || exp_last)
					compare_done(done, 1'b1);      // Sticky from the first last word on
				if (exp_last) begin
					seen_last  = 1'b1;
					stall_mask = 7;                // Heavy stalls for the later streams
				end
				out_pop = 1'b1;
			end
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		seed        = 77455;
		rst_n       = 1'b0;
		in_push     = 1'b0;
		in_data     = '0;
		out_pop     = 1'b0;
		cycle_cnt   = 0;
		stall_mask  = 1;
		seen_last   = 1'b0;
		saw_in_full = 1'b0;

		// First member is a single final block
		add_block(1'b1, rand_len());
		// Second member has four blocks, one of them empty
		add_block(1'b0, rand_len());
		add_block(1'b0, 0);
		add_block(1'b0, rand_len());
		add_block(1'b1, rand_len());
		// Third member follows right behind
		add_block(1'b0, rand_len());
		add_block(1'b1, rand_len());
		cycle_limit = (in_q.size() + exp_data_q.size()) * 20 + 2000;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		compare_flag("out_empty", out_empty, 1'b1);
		compare_flag("in_full", in_full, 1'b0);
		compare_done(done, 1'b0);

		while (exp_data_q.size() > 0) begin
			@(negedge clk);
			drive_input();
			drive_output();
		end
		@(negedge clk);
		in_push = 1'b0;
		out_pop = 1'b0;

		// Nothing more may come out once every member is done
		repeat (20) @(negedge clk);
		compare_flag("out_empty", out_empty, 1'b1);
		compare_done(done, 1'b1);
		if (in_q.size() != 0) begin
			$display("error: %0d input words were never pushed", in_q.size());
			abort_run();
		end else if (!saw_in_full) begin
			$display("error: the input FIFO never filled, so no push was ever held off");
			abort_run();
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule
